//--- hdl/setstream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings stream package
// Bus addresses, sizes and the shared
// set word and beat types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package setstream_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int HALF_W = DATA_W / 2;

  localparam logic [ADDR_W-1:0] CH0_ADDR      = 8'h10;
  localparam logic [ADDR_W-1:0] CH0_LAST_ADDR = 8'h11;  // Same channel, last beat
  localparam logic [ADDR_W-1:0] CH1_ADDR      = 8'h20;

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // One bus word, read whole or as two halves
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [HALF_W-1:0] hi;
      logic [HALF_W-1:0] lo;
    } halves;
  } set_word_u;

  typedef struct packed {
    logic      hit0;
    logic      last0;
    logic      hit1;
    set_word_u word;
  } set_wr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

  typedef struct packed {
    beat_t beat;
    logic  chan;  // Source channel
  } out_beat_t;

endpackage

`default_nettype wire

//--- hdl/set_bus_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings bus decoder
// Registers a bus write and turns its
// address into per-channel hit flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module set_bus_decode
  import setstream_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              i_set_stb,
  input  wire logic [ADDR_W-1:0] i_set_addr,
  input  wire set_word_u         i_set_data,
  output set_wr_t                o_wr
);

  logic              stb_q;
  logic [ADDR_W-1:0] addr_q;
  set_word_u         data_q;

  always_ff @(posedge clk) begin
    addr_q <= i_set_addr;
    data_q <= i_set_data;
    if (reset) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= i_set_stb;
    end
  end

  // At most one flag per write, unmapped addresses fall through
  always_comb begin
    o_wr.hit0  = 1'b0;
    o_wr.last0 = 1'b0;
    o_wr.hit1  = 1'b0;
    o_wr.word  = data_q;
    if (stb_q) begin
      if (addr_q == CH0_ADDR || addr_q == CH0_LAST_ADDR) begin
        o_wr.hit0  = 1'b1;
        o_wr.last0 = (addr_q == CH0_LAST_ADDR);
      end else if (addr_q == CH1_ADDR) begin
        o_wr.hit1 = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/setting_stream_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Setting register with stream output
// Holds one beat per decoded write and
// flags writes that overrun a held beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module setting_stream_reg
  import setstream_pkg::*;
#(
  parameter bit MSB_ALIGN = 1'b0
) (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      i_hit,
  input  wire logic      i_last,
  input  wire set_word_u i_word,
  output beat_t          o_beat,
  output logic           o_valid,
  input  wire logic      i_ready,
  output logic           o_err_stb
);

  logic [DATA_W-1:0] load_data;

  // Upper half moves down, zero filled
  assign load_data = MSB_ALIGN ? {{(DATA_W-HALF_W){1'b0}}, i_word.halves.hi}
                               : i_word.raw;

  always_ff @(posedge clk) begin
    if (i_hit) begin
      o_beat.data <= load_data;
      o_beat.last <= i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid   <= 1'b0;
      o_err_stb <= 1'b0;
    end else begin
      // Held beat is lost when it cannot leave this cycle
      o_err_stb <= i_hit & o_valid & ~i_ready;
      if (i_hit) begin
        o_valid <= 1'b1;  // New beat wins over acceptance
      end else if (o_valid && i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/beat_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat FIFO
// Small circular buffer of stream beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module beat_fifo
  import setstream_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire beat_t i_beat,
  input  wire logic  i_valid,
  output logic       o_ready,
  output beat_t      o_beat,
  output logic       o_valid,
  input  wire logic  i_ready
);

  beat_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign o_valid = (count != '0);
  assign o_beat  = mem[rd_ptr];

  assign push = i_valid & o_ready;
  assign pop  = o_valid & i_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/beat_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat merger
// Round-robin merge of two beat streams
// into one registered, tagged stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module beat_merge
  import setstream_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire beat_t i_beat0,
  input  wire logic  i_valid0,
  output logic       o_ready0,
  input  wire beat_t i_beat1,
  input  wire logic  i_valid1,
  output logic       o_ready1,
  output out_beat_t  o_beat,
  output logic       o_valid,
  input  wire logic  i_ready
);

  logic  last_served;
  logic  slot_free;
  logic  sel;
  logic  take;
  beat_t pick;

  assign slot_free = ~o_valid | i_ready;

  // On contention serve the channel not taken last time
  assign sel  = (i_valid0 & i_valid1) ? ~last_served : i_valid1;
  assign pick = sel ? i_beat1 : i_beat0;
  assign take = slot_free & (i_valid0 | i_valid1);

  assign o_ready0 = slot_free & ~sel;
  assign o_ready1 = slot_free & sel;

  always_ff @(posedge clk) begin
    if (take) begin
      o_beat.beat <= pick;
      o_beat.chan <= sel;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid     <= 1'b0;
      last_served <= 1'b1;  // Channel 0 first after reset
    end else begin
      if (take) begin
        o_valid     <= 1'b1;
        last_served <= sel;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/setstream_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings stream top level
// Bus decoder, two register/FIFO channels
// and the output merger
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module setstream_top
  import setstream_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              i_set_stb,
  input  wire logic [ADDR_W-1:0] i_set_addr,
  input  wire set_word_u         i_set_data,
  output out_beat_t              o_beat,
  output logic                   o_valid,
  input  wire logic              i_ready,
  output logic [1:0]             o_err
);

  set_wr_t wr;
  beat_t   reg_beat0, reg_beat1;
  logic    reg_valid0, reg_valid1;
  logic    reg_ready0, reg_ready1;
  beat_t   fifo_beat0, fifo_beat1;
  logic    fifo_valid0, fifo_valid1;
  logic    fifo_ready0, fifo_ready1;

  set_bus_decode u_decode (
    .clk, .reset, .i_set_stb, .i_set_addr, .i_set_data, .o_wr(wr)
  );

  setting_stream_reg #(.MSB_ALIGN(1'b0)) u_reg0 (
    .clk, .reset, .i_hit(wr.hit0), .i_last(wr.last0), .i_word(wr.word),
    .o_beat(reg_beat0), .o_valid(reg_valid0), .i_ready(reg_ready0), .o_err_stb(o_err[0])
  );

  // Channel 1 never marks last
  setting_stream_reg #(.MSB_ALIGN(1'b1)) u_reg1 (
    .clk, .reset, .i_hit(wr.hit1), .i_last(1'b0), .i_word(wr.word),
    .o_beat(reg_beat1), .o_valid(reg_valid1), .i_ready(reg_ready1), .o_err_stb(o_err[1])
  );

  beat_fifo u_fifo0 (
    .clk, .reset, .i_beat(reg_beat0), .i_valid(reg_valid0), .o_ready(reg_ready0),
    .o_beat(fifo_beat0), .o_valid(fifo_valid0), .i_ready(fifo_ready0)
  );

  beat_fifo u_fifo1 (
    .clk, .reset, .i_beat(reg_beat1), .i_valid(reg_valid1), .o_ready(reg_ready1),
    .o_beat(fifo_beat1), .o_valid(fifo_valid1), .i_ready(fifo_ready1)
  );

  beat_merge u_merge (
    .clk, .reset,
    .i_beat0(fifo_beat0), .i_valid0(fifo_valid0), .o_ready0(fifo_ready0),
    .i_beat1(fifo_beat1), .i_valid1(fifo_valid1), .o_ready1(fifo_ready1),
    .o_beat, .o_valid, .i_ready
  );

endmodule

`default_nettype wire

//--- tests/setstream_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings stream protocol checks
// Output handshake and error strobe rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module setstream_assert
  import setstream_pkg::*;
(
  input wire logic       clk,
  input wire logic       reset,
  input wire out_beat_t  o_beat,
  input wire logic       o_valid,
  input wire logic       i_ready,
  input wire logic [1:0] o_err
);

  // Stalled beat stays put until taken
  hold_stable: assert property (
    @(posedge clk) disable iff (reset)
    o_valid && !i_ready |=> o_valid && $stable(o_beat)
  ) else $error("output beat moved while stalled");

  outputs_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown({o_valid, o_err})
  ) else $error("unknown value on o_valid or o_err");

  err0_pulse: assert property (
    @(posedge clk) disable iff (reset)
    o_err[0] |=> !o_err[0]
  ) else $error("channel 0 error strobe held two cycles");

  err1_pulse: assert property (
    @(posedge clk) disable iff (reset)
    o_err[1] |=> !o_err[1]
  ) else $error("channel 1 error strobe held two cycles");

endmodule

`default_nettype wire

//--- tests/setstream_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings stream testbench
// Bus writes in, tagged beats checked
// against per-channel expected queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module setstream_tb
  import setstream_pkg::*;
();

  localparam int DRAIN_LIMIT = 400;
  localparam int HOLD_MAX    = FIFO_DEPTH + 2;  // FIFO plus register and merger slot

  logic              clk = 1'b0;
  logic              reset;
  logic              i_set_stb;
  logic [ADDR_W-1:0] i_set_addr;
  set_word_u         i_set_data;
  out_beat_t         o_beat;
  logic              o_valid;
  logic              i_ready;
  logic [1:0]        o_err;

  beat_t q0[$];
  beat_t q1[$];
  int    err_cnt[2] = '{0, 0};
  int    exp_err[2] = '{0, 0};
  string test_name  = "reset";

  setstream_top i_dut (.*);

  bind setstream_top setstream_assert u_assert (.*);

  always #20 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    beat_t b;
    @(posedge clk);
    i_set_stb       <= 1'b1;
    i_set_addr      <= addr;
    i_set_data.raw  <= data;
    b.data = data;
    b.last = (addr == CH0_LAST_ADDR);
    if (addr == CH0_ADDR || addr == CH0_LAST_ADDR) begin
      q0.push_back(b);
    end else if (addr == CH1_ADDR) begin
      b.data = {16'h0000, data[31:16]};  // Upper half zero-extended
      b.last = 1'b0;
      q1.push_back(b);
    end
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      i_set_stb <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((q0.size() != 0 || q1.size() != 0) && t < DRAIN_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (q0.size() != 0 || q1.size() != 0) begin
      stop_on_error($sformatf("Timed out in %s waiting for %0d beats",
                              test_name, q0.size() + q1.size()));
    end
  endtask

  task automatic check_errors();
    @(negedge clk);
    assert (err_cnt[0] == exp_err[0] && err_cnt[1] == exp_err[1]) else
      stop_on_error($sformatf("ERR %s o_err pulses expected %0d/%0d actual %0d/%0d",
                              test_name, exp_err[0], exp_err[1], err_cnt[0], err_cnt[1]));
  endtask

  task automatic check_quiet(input string when);
    @(negedge clk);
    assert (!o_valid && o_err == 2'b00) else
      stop_on_error($sformatf("o_valid or o_err went high %s", when));
  endtask

  task automatic check_beat(input out_beat_t got);
    beat_t exp;
    if ((got.chan && q1.size() == 0) || (!got.chan && q0.size() == 0)) begin
      stop_on_error($sformatf("Unexpected beat on channel %0d in %s", got.chan, test_name));
    end else begin
      if (got.chan) begin
        exp = q1.pop_front();
      end else begin
        exp = q0.pop_front();
      end
      assert (got.beat == exp) else
        stop_on_error($sformatf("ERR %s chan %0d expected %h/%0b actual %h/%0b", test_name,
                                got.chan, exp.data, exp.last, got.beat.data, got.beat.last));
    end
  endtask

  // Output monitor and error strobe counter
  always @(posedge clk) begin
    if (!reset) begin
      if (o_err[0]) err_cnt[0]++;
      if (o_err[1]) err_cnt[1]++;
      if (o_valid && i_ready) check_beat(o_beat);
    end
  end

  initial begin
    int                held;
    logic [ADDR_W-1:0] addr;
    void'($urandom(32'hb7be_0240));
    reset      = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_ready    = 1'b1;
    repeat (7) check_quiet("during reset");
    @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);  // First edge with reset low
    check_quiet("right after reset");

    test_name = "ch0_words";
    repeat (12) begin
      bus_write(($urandom_range(1, 0) != 0) ? CH0_LAST_ADDR : CH0_ADDR, $urandom());
      bus_idle(1);
    end
    wait_drain();
    check_errors();

    test_name = "ch1_msb";
    repeat (12) begin
      bus_write(CH1_ADDR, $urandom());
      bus_idle(1);
    end
    wait_drain();
    check_errors();

    test_name = "unmapped";
    repeat (16) begin
      addr = ADDR_W'($urandom_range(255, 0));
      if (addr == CH0_ADDR || addr == CH0_LAST_ADDR || addr == CH1_ADDR) addr = addr ^ 8'h80;
      bus_write(addr, $urandom());
      bus_idle(1);
    end
    bus_idle(10);
    check_errors();

    test_name = "interleave";
    repeat (16) begin
      bus_write(($urandom_range(1, 0) != 0) ? CH0_LAST_ADDR : CH0_ADDR, $urandom());
      bus_write(CH1_ADDR, $urandom());
    end
    bus_idle(1);
    wait_drain();
    check_errors();

    test_name = "overrun";
    @(posedge clk);
    i_ready <= 1'b0;
    held = 0;
    repeat (HOLD_MAX + 3) begin
      if (held == HOLD_MAX) begin
        void'(q0.pop_back());  // Held value gets replaced
        exp_err[0]++;
      end else begin
        held++;
      end
      bus_write(CH0_ADDR, $urandom());
      bus_idle(4);
      check_errors();
    end
    @(posedge clk);
    i_ready <= 1'b1;
    wait_drain();
    check_errors();

    test_name = "final";
    bus_idle(10);
    if (q0.size() == 0 && q1.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_on_error("Expected beats still queued at end of run");
    end
  end

endmodule

`default_nettype wire

//--- files.f
hdl/setstream_pkg.sv
hdl/set_bus_decode.sv
hdl/setting_stream_reg.sv
hdl/beat_fifo.sv
hdl/beat_merge.sv
hdl/setstream_top.sv
tests/setstream_assert.sv
tests/setstream_tb.sv

//--- run.sh
#!/bin/sh
# Build the settings stream testbench with Verilator and run it
verilator --binary --timing --assert --top-module setstream_tb -f files.f -o setstream_sim \
  && ./obj_dir/setstream_sim \
  || exit 1
